// File: hw/colmix_defs.svh
// --------------------------------------------------
// colour mixer shared sizes
// memory address widths, colour depth and the
// blanking delay that lines up with the colour path
// --------------------------------------------------

`ifndef COLMIX_DEFS_SVH
`define COLMIX_DEFS_SVH

// palette address, 2-bit layer prefix plus 7-bit colour
`define COLMIX_PAL_AW 9

// priority PROM address, see layer_prio for bit order
`define COLMIX_PRIO_AW 8

// bits per colour channel at the output
`define COLMIX_COLOR_W 4

// pixel-enable steps from blank inputs to lvbl_dly/lhbl_dly
`define COLMIX_BLANK_STAGES 5

`endif

// File: hw/colmix_pkg.sv
// --------------------------------------------------
// colour mixer types
// layer pixels, cpu and prom ports, palette entries
// --------------------------------------------------

`include "colmix_defs.svh"

package colmix_pkg;

    // one pixel from each layer, 23 bits
    typedef struct packed {
        logic [6:0] char_pxl;   // character layer
        logic [7:0] obj_pxl;    // object layer, bit 7 is priority
        logic [7:0] scr_pxl;    // scroll layer, bit 7 is priority
    } layer_pix_t;

    // cpu side of the palette, addr[9] picks the blue bank
    typedef struct packed {
        logic [9:0] addr;
        logic [7:0] dout;       // data from cpu
        logic       wr_n;
        logic       cs;
    } cpu_bus_t;

    // priority prom load port
    typedef struct packed {
        logic [7:0] addr;
        logic [1:0] din;
        logic       we;
    } prom_prog_t;

    // visible layer code, both low codes mean char
    typedef enum logic [1:0] {
        PRIO_CHAR  = 2'd0,
        PRIO_CHAR1 = 2'd1,
        PRIO_OBJ   = 2'd2,
        PRIO_SCR   = 2'd3
    } prio_t;

    typedef logic [7:0] gr_entry_t;    // green high nibble, red low
    typedef logic [3:0] b_entry_t;     // blue only

    typedef struct packed {
        logic [`COLMIX_COLOR_W-1:0] red;
        logic [`COLMIX_COLOR_W-1:0] green;
        logic [`COLMIX_COLOR_W-1:0] blue;
    } rgb_t;

endpackage

// File: hw/video_ram.sv
// --------------------------------------------------
// simple dual port ram
// one write port, one registered read port,
// entry type set per instance
// --------------------------------------------------

module video_ram #(
    parameter type entry_t = logic [7:0],
    parameter int  AW      = 8
) (
    input  logic          clk,
    input  logic          we,
    input  logic [AW-1:0] wr_addr,
    input  entry_t        wr_data,
    input  logic [AW-1:0] rd_addr,
    output entry_t        rd_data
);

    localparam int DEPTH = 2 ** AW;

    entry_t mem [DEPTH];   // contents undefined until written

    // write side
    always_ff @(posedge clk) begin
        if (we) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // read side, one clk latency
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

// File: hw/layer_prio.sv
// --------------------------------------------------
// layer priority select
// finds blank layers, looks up the priority prom and
// builds the palette address of the visible pixel
// --------------------------------------------------

`include "colmix_defs.svh"

module layer_prio (
    input  logic                      clk,
    input  colmix_pkg::layer_pix_t    pix,
    input  colmix_pkg::prom_prog_t    prog,
    output logic [`COLMIX_PAL_AW-1:0] pix_addr
);

    logic                          char_blank;
    logic                          obj_blank;
    logic [`COLMIX_PRIO_AW-1:0]    sel_addr;
    colmix_pkg::prio_t             prio;
    colmix_pkg::prio_t             prog_code;
    colmix_pkg::layer_pix_t        pix_q;     // lines up with prio

    // transparent pen is colour 0 of the low nibble
    assign char_blank = ~|pix.char_pxl[3:0];
    assign obj_blank  = ~|pix.obj_pxl[3:0];

    // prom address, msb first
    assign sel_addr = {
        pix.scr_pxl[7],      // scroll priority bit
        pix.obj_pxl[7],      // object priority bit
        obj_blank,
        char_blank,
        pix.scr_pxl[3:0]     // scroll colour nibble
    };

    assign prog_code = colmix_pkg::prio_t'(prog.din);

    video_ram #(
        .entry_t (colmix_pkg::prio_t),
        .AW      (`COLMIX_PRIO_AW)
    ) u_prom (
        .clk     (clk),
        .we      (prog.we),
        .wr_addr (prog.addr),
        .wr_data (prog_code),
        .rd_addr (sel_addr),
        .rd_data (prio)
    );

    // one clk delay to match the prom read
    always_ff @(posedge clk) begin
        pix_q <= pix;
    end

    // bank prefix in the top two address bits
    always_comb begin
        case (prio)
            colmix_pkg::PRIO_OBJ: begin
                pix_addr = {2'b01, pix_q.obj_pxl[6:0]};
            end
            colmix_pkg::PRIO_SCR: begin
                pix_addr = {2'b10, pix_q.scr_pxl[6:0]};
            end
            default: begin
                pix_addr = {2'b00, pix_q.char_pxl};   // codes 0 and 1
            end
        endcase
    end

endmodule

// File: hw/palette_access.sv
// --------------------------------------------------
// palette access
// shares the palette address between cpu and pixels,
// holds the green-red and blue banks, cpu readback
// --------------------------------------------------

`include "colmix_defs.svh"

module palette_access (
    input  logic                      clk,
    input  logic                      rst_n,
    input  colmix_pkg::cpu_bus_t      cpu,
    input  logic [`COLMIX_PAL_AW-1:0] pix_addr,
    output colmix_pkg::gr_entry_t     gr,
    output colmix_pkg::b_entry_t      b,
    output logic [7:0]                pal_dout
);

    logic [`COLMIX_PAL_AW-1:0] pal_addr;    // shared address register
    logic                      gr_we;
    logic                      b_we;
    logic [7:0]                pal_din;     // cpu data, registered
    colmix_pkg::gr_entry_t     gr_din;
    colmix_pkg::b_entry_t      b_din;
    logic                      rd_blue;     // bank of pal_addr
    logic                      rd_blue_q;   // bank of gr/b outputs

    // cpu wins the address whenever selected
    always_ff @(posedge clk) begin
        if (cpu.cs) begin
            pal_addr <= cpu.addr[`COLMIX_PAL_AW-1:0];
        end else begin
            pal_addr <= pix_addr;
        end
        rd_blue   <= cpu.addr[9];
        rd_blue_q <= rd_blue;   // follows the ram read
        pal_din   <= cpu.dout;
    end

    // bank write strobes, addr[9] splits the banks
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            gr_we <= 1'b0;
            b_we  <= 1'b0;
        end else begin
            gr_we <= cpu.cs && !cpu.wr_n && !cpu.addr[9];
            b_we  <= cpu.cs && !cpu.wr_n &&  cpu.addr[9];
        end
    end

    assign gr_din = colmix_pkg::gr_entry_t'(pal_din);
    assign b_din  = colmix_pkg::b_entry_t'(pal_din[3:0]);   // low nibble only

    video_ram #(
        .entry_t (colmix_pkg::gr_entry_t),
        .AW      (`COLMIX_PAL_AW)
    ) u_pal_gr (
        .clk     (clk),
        .we      (gr_we),
        .wr_addr (pal_addr),
        .wr_data (gr_din),
        .rd_addr (pal_addr),
        .rd_data (gr)
    );

    video_ram #(
        .entry_t (colmix_pkg::b_entry_t),
        .AW      (`COLMIX_PAL_AW)
    ) u_pal_b (
        .clk     (clk),
        .we      (b_we),
        .wr_addr (pal_addr),
        .wr_data (b_din),
        .rd_addr (pal_addr),
        .rd_data (b)
    );

    // readback byte, unused upper bits of blue read as ones
    always_ff @(posedge clk) begin
        if (rd_blue_q) begin
            pal_dout <= {4'hf, b};
        end else begin
            pal_dout <= gr;
        end
    end

endmodule

// File: hw/video_out.sv
// --------------------------------------------------
// video output stage
// blanks and registers rgb on the pixel enable,
// delays the blanking flags to match
// --------------------------------------------------

`include "colmix_defs.svh"

module video_out (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  pxl_cen,
    input  logic                  vbl,
    input  logic                  hbl,
    input  colmix_pkg::gr_entry_t gr,
    input  colmix_pkg::b_entry_t  b,
    output colmix_pkg::rgb_t      rgb,
    output logic                  lvbl_dly,
    output logic                  lhbl_dly
);

    localparam int STAGES = `COLMIX_BLANK_STAGES;

    logic                    blank;
    logic [STAGES-1:0][1:0]  blank_sh;    // {lvbl, lhbl} per stage

    assign blank = vbl | hbl;

    // colour register
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rgb <= '0;
        end else if (pxl_cen) begin
            if (blank) begin
                rgb <= '0;   // black outside the active area
            end else begin
                rgb.red   <= gr[3:0];
                rgb.green <= gr[7:4];
                rgb.blue  <= b;
            end
        end
    end

    // active-high visible flags, shifted on pxl_cen
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            blank_sh <= '0;
        end else if (pxl_cen) begin
            blank_sh <= {blank_sh[STAGES-2:0], ~vbl, ~hbl};
        end
    end

    assign lvbl_dly = blank_sh[STAGES-1][1];
    assign lhbl_dly = blank_sh[STAGES-1][0];

endmodule

// File: hw/colmix_top.sv
// --------------------------------------------------
// colour mixer top
// priority select, palette and video output wired
// together with the cpu and prom load ports
// --------------------------------------------------

`include "colmix_defs.svh"

module colmix_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   pxl_cen,
    input  colmix_pkg::layer_pix_t pix,
    input  logic                   vbl,
    input  logic                   hbl,
    input  colmix_pkg::cpu_bus_t   cpu,
    output logic [7:0]             pal_dout,
    input  colmix_pkg::prom_prog_t prog,
    output logic                   lvbl_dly,
    output logic                   lhbl_dly,
    output colmix_pkg::rgb_t       rgb
);

    logic [`COLMIX_PAL_AW-1:0] pix_addr;   // visible layer palette index
    colmix_pkg::gr_entry_t     gr;
    colmix_pkg::b_entry_t      b;

    layer_prio u_prio (
        .clk      (clk),
        .pix      (pix),
        .prog     (prog),
        .pix_addr (pix_addr)
    );

    palette_access u_pal (
        .clk      (clk),
        .rst_n    (rst_n),
        .cpu      (cpu),
        .pix_addr (pix_addr),
        .gr       (gr),
        .b        (b),
        .pal_dout (pal_dout)
    );

    video_out u_out (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .vbl      (vbl),
        .hbl      (hbl),
        .gr       (gr),
        .b        (b),
        .rgb      (rgb),
        .lvbl_dly (lvbl_dly),
        .lhbl_dly (lhbl_dly)
    );

endmodule

// File: tests/colmix_assertions.sv
// --------------------------------------------------
// colour mixer assertions
// blanking of rgb, blank flag delay and the cpu
// write strobes of the palette banks
// --------------------------------------------------

`include "colmix_defs.svh"

module colmix_assertions (
    input logic             clk,
    input logic             rst_n,
    input logic             pxl_cen,
    input logic             vbl,
    input logic             hbl,
    input logic             cs,
    input logic             gr_we,
    input logic             b_we,
    input colmix_pkg::rgb_t rgb,
    input logic             lvbl_dly
);

    localparam int STAGES = `COLMIX_BLANK_STAGES;

    logic [STAGES-1:0] lvbl_hist;   // inverted vbl per pixel step
    int                blank_errs = 0;
    int                delay_errs = 0;
    int                write_errs = 0;
    int                fail_cnt;    // all failed properties

    assign fail_cnt = blank_errs + delay_errs + write_errs;

    // history of inverted vbl, cleared on reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lvbl_hist <= '0;
        end else if (pxl_cen) begin
            lvbl_hist <= {lvbl_hist[STAGES-2:0], ~vbl};
        end
    end

    // blank sampled on a pixel step gives black next clk
    blank_black: assert property (@(posedge clk) disable iff (!rst_n)
        (pxl_cen && (vbl || hbl)) |=> (rgb == '0))
        else begin
            $error("rgb not black after a blanked pixel step");
            blank_errs++;
        end

    // oldest history stage lines up with lvbl_dly
    vbl_delay: assert property (@(posedge clk) disable iff (!rst_n)
        lvbl_dly == lvbl_hist[STAGES-1])
        else begin
            $error("lvbl_dly does not follow vbl by the blank delay");
            delay_errs++;
        end

    // no bank write without chip select
    no_stray_write: assert property (@(posedge clk) disable iff (!rst_n)
        !cs |=> !(gr_we || b_we))
        else begin
            $error("palette write enable high without chip select");
            write_errs++;
        end

endmodule

bind colmix_top colmix_assertions colmix_assertions_i (
    .clk      (clk),
    .rst_n    (rst_n),
    .pxl_cen  (pxl_cen),
    .vbl      (vbl),
    .hbl      (hbl),
    .cs       (cpu.cs),
    .gr_we    (u_pal.gr_we),
    .b_we     (u_pal.b_we),
    .rgb      (rgb),
    .lvbl_dly (lvbl_dly)
);

// File: tests/colmix_tb.sv
// --------------------------------------------------
// colour mixer testbench
// loads prom and palette and reads the palette back
// then checks rgb and blank delay against a model
// --------------------------------------------------

`include "colmix_defs.svh"

module colmix_tb;

    typedef struct packed {
        colmix_pkg::layer_pix_t pix;
        logic vbl;
        logic hbl;
        logic cen;
        logic ok;               // colour path valid for this edge
    } hist_t;

    logic                   clk;
    logic                   rst_n;
    logic                   pxl_cen;
    logic                   vbl;
    logic                   hbl;
    logic                   chk_en;
    colmix_pkg::layer_pix_t pix;
    colmix_pkg::cpu_bus_t   cpu;
    colmix_pkg::prom_prog_t prog;
    colmix_pkg::rgb_t       rgb;
    logic [7:0]             pal_dout;
    logic                   lvbl_dly;
    logic                   lhbl_dly;
    logic [1:0]             prom_mdl [256];      // written prom codes
    logic [7:0]             gr_mdl [512];
    logic [3:0]             b_mdl [512];
    hist_t                  hist [$];            // recent sampled inputs
    int                     err_cnt;
    int                     chk_cnt;
    int                     asrt_cnt;            // bound property failures

    colmix_top colmix_top_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .pxl_cen  (pxl_cen),
        .pix      (pix),
        .vbl      (vbl),
        .hbl      (hbl),
        .cpu      (cpu),
        .pal_dout (pal_dout),
        .prog     (prog),
        .lvbl_dly (lvbl_dly),
        .lhbl_dly (lhbl_dly),
        .rgb      (rgb)
    );

    initial clk = 1'b0;
    always #10 clk = ~clk;

    // to 2 units after the next rising edge
    task automatic step();
        @(posedge clk);
        #2;
    endtask

    task automatic step_n(input int n);
        for (int i = 0; i < n; i++) begin
            step();
        end
    endtask

    // low nibbles often zero to hit the blank bits
    function automatic colmix_pkg::layer_pix_t random_pixel();
        logic [31:0]            r;
        colmix_pkg::layer_pix_t p;
        r = $urandom;
        p = r[22:0];
        if ($urandom % 4 == 0) p.char_pxl[3:0] = 4'h0;
        if ($urandom % 4 == 0) p.obj_pxl[3:0] = 4'h0;
        return p;
    endfunction

    // colour from the layer rules and the written tables
    function automatic colmix_pkg::rgb_t expect_colour(colmix_pkg::layer_pix_t p);
        logic [7:0]       paddr;
        logic [8:0]       caddr;
        colmix_pkg::rgb_t c;
        paddr = {p.scr_pxl[7], p.obj_pxl[7], p.obj_pxl[3:0] == 4'h0,
                 p.char_pxl[3:0] == 4'h0, p.scr_pxl[3:0]};
        case (prom_mdl[paddr])
            2'd2:    caddr = {2'b01, p.obj_pxl[6:0]};
            2'd3:    caddr = {2'b10, p.scr_pxl[6:0]};
            default: caddr = {2'b00, p.char_pxl};
        endcase
        c.red   = gr_mdl[caddr][3:0];
        c.green = gr_mdl[caddr][7:4];
        c.blue  = b_mdl[caddr];
        return c;
    endfunction

    task automatic cpu_write(input logic [9:0] a, input logic [7:0] d);
        step();
        cpu = '{addr: a, dout: d, wr_n: 1'b0, cs: 1'b1};
        if (a[9]) b_mdl[a[8:0]] = d[3:0];
        else gr_mdl[a[8:0]] = d;
    endtask

    task automatic cpu_read_check(input logic [9:0] a);
        logic [7:0] exp_d;
        step();
        cpu = '{addr: a, dout: 8'h00, wr_n: 1'b1, cs: 1'b1};
        step_n(3);                               // pal_dout three edges later
        exp_d = a[9] ? {4'hf, b_mdl[a[8:0]]} : gr_mdl[a[8:0]];
        chk_cnt++;
        assert (pal_dout === exp_d) else begin
            err_cnt++;
            $display("mismatch at %0t: pal_dout %h for addr %h, expected %h",
                     $time, pal_dout, a, exp_d);
        end
    endtask

    // model checks rgb and lhbl_dly 1 unit after every edge
    always begin : model
        hist_t            rec;
        int               c_idx;
        int               d_idx;
        int               seen;
        logic             path_ok;
        colmix_pkg::rgb_t exp_rgb;
        @(posedge clk);
        #1;
        if (!rst_n) begin
            hist.delete();
        end else begin
            rec = '{pix: pix, vbl: vbl, hbl: hbl, cen: pxl_cen, ok: chk_en && !cpu.cs};
            hist.push_back(rec);
            if (hist.size() > 16) void'(hist.pop_front());
            c_idx = -1;
            d_idx = -1;
            seen  = 0;
            for (int i = hist.size() - 1; i >= 0; i--) begin
                if (hist[i].cen) begin
                    seen++;
                    if (seen == 1) c_idx = i;                     // last rgb update
                    if (seen == `COLMIX_BLANK_STAGES) d_idx = i;  // blank delay tap
                end
            end
            if (c_idx >= 3) begin
                path_ok = hist[c_idx].ok && hist[c_idx-1].ok &&
                          hist[c_idx-2].ok && hist[c_idx-3].ok;
                if (path_ok) begin
                    if (hist[c_idx].vbl || hist[c_idx].hbl) exp_rgb = '0;
                    else exp_rgb = expect_colour(hist[c_idx-3].pix);
                    chk_cnt++;
                    assert (rgb === exp_rgb) else begin
                        err_cnt++;
                        $display("mismatch at %0t: rgb %h, expected %h", $time, rgb, exp_rgb);
                    end
                end
            end
            if (d_idx >= 0) begin
                chk_cnt++;
                assert (lhbl_dly === ~hist[d_idx].hbl) else begin
                    err_cnt++;
                    $display("mismatch at %0t: lhbl_dly %b, expected %b",
                             $time, lhbl_dly, ~hist[d_idx].hbl);
                end
            end
        end
    end

    initial begin : watchdog
        for (int n = 0; n < 20000; n++) begin
            @(posedge clk);
        end
        $display("timeout: the run did not finish within 20000 clock cycles");
        $display("TEST FAILED");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] r;
        void'($urandom(75));
        rst_n   = 1'b0;
        pxl_cen = 1'b1;
        vbl     = 1'b0;
        hbl     = 1'b0;
        chk_en  = 1'b0;
        pix     = '0;
        cpu     = '{addr: 10'h000, dout: 8'h00, wr_n: 1'b1, cs: 1'b0};
        prog    = '0;
        err_cnt = 0;
        chk_cnt = 0;
        step_n(10);
        chk_cnt++;
        assert (rgb === '0 && lvbl_dly === 1'b0 && lhbl_dly === 1'b0) else begin
            err_cnt++;
            $display("mismatch at %0t: outputs not cleared by reset", $time);
        end
        rst_n = 1'b1;

        // one priority code per prom address
        for (int a = 0; a < 256; a++) begin
            step();
            r = $urandom;
            prog = '{addr: a[7:0], din: r[1:0], we: 1'b1};
            prom_mdl[a] = r[1:0];
        end
        step();
        prog.we = 1'b0;

        // fill both palette banks and read every entry back
        for (int a = 0; a < 1024; a++) begin
            r = $urandom;
            cpu_write(a[9:0], r[7:0]);
        end
        for (int a = 0; a < 1024; a++) begin
            cpu_read_check(a[9:0]);
        end
        step();
        cpu = '{addr: 10'h000, dout: 8'h00, wr_n: 1'b1, cs: 1'b0};

        // random pixels without blanking
        chk_en = 1'b1;
        for (int n = 0; n < 1500; n++) begin
            step();
            pix = random_pixel();
        end

        // pixel enable every other clk with random blank pulses
        for (int n = 0; n < 1500; n++) begin
            step();
            pix     = random_pixel();
            pxl_cen = ~pxl_cen;
            if ($urandom % 10 == 0) vbl = ~vbl;
            if ($urandom % 6 == 0) hbl = ~hbl;
        end
        step_n(8);
        chk_en = 1'b0;

        asrt_cnt = colmix_top_i.colmix_assertions_i.fail_cnt;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 chk_cnt, err_cnt, asrt_cnt);
        if (err_cnt == 0 && asrt_cnt == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+hw
hw/colmix_pkg.sv
hw/video_ram.sv
hw/layer_prio.sv
hw/palette_access.sv
hw/video_out.sv
hw/colmix_top.sv
tests/colmix_assertions.sv
tests/colmix_tb.sv

// File: Makefile
# Verilator build and run for the colour mixer testbench

SRCS := $(wildcard hw/*.sv hw/*.svh tests/*.sv)

.PHONY: all run clean

all: obj_dir/Vcolmix_tb

obj_dir/Vcolmix_tb: $(SRCS) list.f
	verilator --binary --timing --assert --top-module colmix_tb -f list.f

run: obj_dir/Vcolmix_tb
	./obj_dir/Vcolmix_tb 2>&1 | tee sim.log
	@if grep -q "TEST FAILED" sim.log || ! grep -q "TEST PASSED" sim.log; then \
		echo "simulation failed, see sim.log"; \
		exit 1; \
	fi
	@echo "simulation passed"

clean:
	rm -rf obj_dir sim.log
